/* logic/tape_pkg.sv */
package tape_pkg;

	// word formats, encoded as {stereo, wide}
	typedef enum logic [1:0] {
		mono8    = 2'b00,
		mono16   = 2'b01,
		stereo8  = 2'b10,
		stereo16 = 2'b11
	} fmt_t;

	// register index, taken from adr[3:1]
	localparam logic [2:0] reg_ctrl = 3'd0;
	localparam logic [2:0] reg_ptr  = 3'd1;
	localparam logic [2:0] reg_size = 3'd2;

	localparam int ptr_w  = 14; // head and tail
	localparam int rate_w = 11; // sample rate divider

	// sample memory size limits in bytes
	localparam int mem_min = 1280;
	localparam int mem_max = 16384;

endpackage

/* logic/tape_ctrl_if.sv */
interface tape_ctrl_if;

	logic                        playing;
	logic                        one_bit;
	logic                        stereo;
	logic                        wide;
	logic [tape_pkg::rate_w-1:0] sample_rate;
	logic [tape_pkg::ptr_w-1:0]  tail;
	logic                        head_load;  // one cycle, same edge as bus write
	logic [tape_pkg::ptr_w-1:0]  head_value;

	modport regs (
		output playing,
		output one_bit,
		output stereo,
		output wide,
		output sample_rate,
		output tail,
		output head_load,
		output head_value
	);

	modport play (
		input playing,
		input one_bit,
		input stereo,
		input wide,
		input sample_rate,
		input tail,
		input head_load,
		input head_value
	);

endinterface

/* logic/tape_regs.sv */
module tape_regs #(
	parameter int memory_size = 8192
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [13:0]                adr,
	input  logic                       cs,
	input  logic [3:0]                 sel,
	input  logic                       we,
	input  logic [31:0]                d,
	input  logic [tape_pkg::ptr_w-1:0] head,
	output logic [31:0]                q,
	tape_ctrl_if.regs                  ctrl
);

	logic                        reg_wr;
	logic [2:0]                  idx;
	logic                        playing;
	logic                        one_bit;
	tape_pkg::fmt_t              fmt;
	logic [tape_pkg::rate_w-1:0] rate;
	logic [tape_pkg::ptr_w-1:0]  tail;

	assign idx    = adr[3:1];
	assign reg_wr = cs && we && adr[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			playing <= 1'b0;
			one_bit <= 1'b0;
			fmt     <= tape_pkg::mono8;
			rate    <= '1; // slowest pacing
			tail    <= '0;
		end else if (reg_wr) begin
			case (idx)
			tape_pkg::reg_ctrl: begin
				if (sel[1]) begin
					one_bit <= d[19];
					fmt     <= tape_pkg::fmt_t'(d[18:17]);
					playing <= d[16];
				end
				if (sel[2])
					rate[10:8] <= d[10:8];
				if (sel[3])
					rate[7:0] <= d[7:0];
			end
			tape_pkg::reg_ptr: begin
				if (sel[2])
					tail[13:8] <= d[13:8];
				if (sel[3])
					tail[7:0] <= d[7:0];
			end
			default: ;
			endcase
		end
	end

	// head itself lives in the buffer, merge the written bytes here
	assign ctrl.head_load  = reg_wr && (idx == tape_pkg::reg_ptr) && (sel[0] || sel[1]);
	assign ctrl.head_value = {sel[0] ? d[29:24] : head[13:8],
	                          sel[1] ? d[23:16] : head[7:0]};

	assign ctrl.playing     = playing;
	assign ctrl.one_bit     = one_bit;
	assign ctrl.stereo      = fmt[1];
	assign ctrl.wide        = fmt[0];
	assign ctrl.sample_rate = rate;
	assign ctrl.tail        = tail;

	always_comb begin
		q = '0;
		case (idx)
		tape_pkg::reg_ctrl: begin
			q[19:16] = {one_bit, fmt, playing};
			q[10:0]  = rate;
		end
		tape_pkg::reg_ptr: begin
			q[29:16] = head;
			q[13:0]  = tail;
		end
		tape_pkg::reg_size: begin
			q[31:16] = 16'(memory_size);
		end
		default: ;
		endcase
	end

endmodule

/* logic/tape_buffer.sv */
module tape_buffer #(
	parameter int memory_size = 8192
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [13:0]                adr,
	input  logic                       cs,
	input  logic [3:0]                 sel,
	input  logic                       we,
	input  logic [31:0]                d,
	input  logic                       word_empty,
	output logic [tape_pkg::ptr_w-1:0] head,
	output logic [31:0]                fetched_word,
	output logic                       word_valid,
	tape_ctrl_if.play                  ctrl
);

	localparam int depth = memory_size / 4; // in words
	localparam int aw    = $clog2(depth);
	localparam logic [tape_pkg::ptr_w-1:0] wrap_mask = tape_pkg::ptr_w'(depth - 1);

	if (memory_size > tape_pkg::mem_max) begin : g_size_max
		initial $fatal(1, "tape memory is limited to %0d bytes", tape_pkg::mem_max);
	end
	if (memory_size < tape_pkg::mem_min) begin : g_size_min
		initial $fatal(1, "tape memory needs at least %0d bytes", tape_pkg::mem_min);
	end
	if ((memory_size & (memory_size - 1)) != 0) begin : g_size_pow2
		initial $fatal(1, "tape memory size must be a power of two");
	end

	logic [7:0]    mem [4][depth]; // lane 0 holds the first played byte
	logic [aw-1:0] wr_idx;
	logic [aw-1:0] rd_idx;
	logic          fetch;

	assign wr_idx = adr[aw:1];
	assign rd_idx = head[aw-1:0];

	// one word in flight at most
	assign fetch = ctrl.playing && word_empty && !word_valid && (head != ctrl.tail);

	always_ff @(posedge clk) begin
		if (cs && we && !adr[0]) begin
			for (int i = 0; i < 4; i++) begin
				if (sel[i])
					mem[i][wr_idx] <= d[31 - 8*i -: 8];
			end
		end
		if (fetch)
			fetched_word <= {mem[0][rd_idx], mem[1][rd_idx], mem[2][rd_idx], mem[3][rd_idx]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head       <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= fetch;
			if (ctrl.head_load)
				head <= ctrl.head_value & wrap_mask; // host write wins over fetch
			else if (fetch)
				head <= (head + 1'b1) & wrap_mask;
		end
	end

endmodule

/* logic/tape_unpack.sv */
module tape_unpack (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] fetched_word,
	input  logic        word_valid,
	input  logic        tick,
	output logic        word_empty,
	output logic [15:0] sample,
	output logic        sample_valid,
	tape_ctrl_if.play   ctrl
);

	logic [31:0]    word;
	logic [31:0]    word_shifted;
	logic           avail;
	logic [4:0]     cnt;
	logic [4:0]     last_cnt;
	logic           step;
	logic           phase;
	logic           pulse;
	logic           pulse_nxt;
	tape_pkg::fmt_t fmt;
	logic [15:0]    left16;
	logic [15:0]    right16;
	logic [8:0]     mix8;
	logic [16:0]    mix16;

	assign fmt          = tape_pkg::fmt_t'({ctrl.stereo, ctrl.wide});
	assign word_empty   = !avail;
	assign sample_valid = tick && avail;

	// 16 bit samples are stored low byte first
	assign left16  = {word[23:16], word[31:24]};
	assign right16 = {word[7:0], word[15:8]};
	assign mix8    = {1'b0, word[31:24]} + {1'b0, word[23:16]};
	assign mix16   = {left16[15], left16} + {right16[15], right16};

	// pulse cell: edge every first half, mid edge only for a one bit
	assign pulse_nxt = phase ? (pulse ^ word[31]) : ~pulse;
	assign step      = !ctrl.one_bit || phase;

	always_comb begin
		sample       = '0;
		last_cnt     = 5'd0;
		word_shifted = word;
		if (ctrl.one_bit) begin
			sample   = {pulse_nxt, 1'b1, 14'h0000};
			last_cnt = 5'd31;
			if (phase)
				word_shifted = {word[30:0], 1'b0};
		end else begin
			case (fmt)
			tape_pkg::mono8: begin
				sample       = {~word[31], word[30:24], word[31:24]};
				last_cnt     = 5'd3;
				word_shifted = {word[23:0], 8'h00};
			end
			tape_pkg::mono16: begin
				sample       = left16;
				last_cnt     = 5'd1;
				word_shifted = {word[15:0], 16'h0000};
			end
			tape_pkg::stereo8: begin
				sample       = {~mix8[8], mix8[7:1], mix8[8:1]}; // top 8 of the sum
				last_cnt     = 5'd1;
				word_shifted = {word[15:0], 16'h0000};
			end
			tape_pkg::stereo16: begin
				sample   = mix16[16:1];
				last_cnt = 5'd0;
			end
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			avail <= 1'b0;
			cnt   <= 5'd0;
			phase <= 1'b0;
			pulse <= 1'b0;
		end else if (!ctrl.playing) begin
			avail <= 1'b0; // drop held word
			phase <= 1'b0;
			pulse <= 1'b0;
		end else if (word_valid) begin
			avail <= 1'b1;
			cnt   <= 5'd0;
			phase <= 1'b0;
		end else if (sample_valid) begin
			if (ctrl.one_bit) begin
				phase <= ~phase;
				pulse <= pulse_nxt;
			end
			if (step) begin
				cnt <= cnt + 5'd1;
				if (cnt == last_cnt)
					avail <= 1'b0; // word used up
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_valid)
			word <= fetched_word;
		else if (sample_valid)
			word <= word_shifted;
	end

endmodule

/* logic/tape_output.sv */
module tape_output (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_3mhz_en,
	input  logic        cs1_cntrl,
	input  logic [15:0] sample,
	input  logic        sample_valid,
	output logic        tick,
	output logic [15:0] tape_audio,
	tape_ctrl_if.play   ctrl
);

	logic [tape_pkg::rate_w-1:0] rate_cnt;

	assign tick = ctrl.playing && clk_3mhz_en && cs1_cntrl && (rate_cnt == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			tape_audio <= '0;
			rate_cnt   <= '0;
		end else if (!ctrl.playing) begin
			tape_audio <= '0;
			rate_cnt   <= '0;
		end else if (clk_3mhz_en) begin
			if (!cs1_cntrl) begin
				tape_audio <= '0; // muted, divider holds
			end else if (tick) begin
				rate_cnt <= ctrl.sample_rate;
				if (sample_valid)
					tape_audio <= sample; // starved tick keeps last value
			end else begin
				rate_cnt <= rate_cnt - 1'b1;
			end
		end
	end

endmodule

/* logic/tape_top.sv */
module tape_top #(
	parameter int memory_size = 8192
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_3mhz_en,
	input  logic [13:0] adr,
	input  logic        cs,
	input  logic [3:0]  sel,
	input  logic        we,
	input  logic [31:0] d,
	input  logic        cs1_cntrl,
	output logic [31:0] q,
	output logic [15:0] tape_audio
);

	logic [tape_pkg::ptr_w-1:0] head;
	logic [31:0]                fetched_word;
	logic                       word_valid;
	logic                       word_empty;
	logic                       tick;
	logic [15:0]                sample;
	logic                       sample_valid;

	tape_ctrl_if ctrl ();

	tape_regs #(
		.memory_size(memory_size)
	) u_regs (
		.clk   (clk),
		.reset (reset),
		.adr   (adr),
		.cs    (cs),
		.sel   (sel),
		.we    (we),
		.d     (d),
		.head  (head),
		.q     (q),
		.ctrl  (ctrl.regs)
	);

	tape_buffer #(
		.memory_size(memory_size)
	) u_buffer (
		.clk          (clk),
		.reset        (reset),
		.adr          (adr),
		.cs           (cs),
		.sel          (sel),
		.we           (we),
		.d            (d),
		.word_empty   (word_empty),
		.head         (head),
		.fetched_word (fetched_word),
		.word_valid   (word_valid),
		.ctrl         (ctrl.play)
	);

	tape_unpack u_unpack (
		.clk          (clk),
		.reset        (reset),
		.fetched_word (fetched_word),
		.word_valid   (word_valid),
		.tick         (tick),
		.word_empty   (word_empty),
		.sample       (sample),
		.sample_valid (sample_valid),
		.ctrl         (ctrl.play)
	);

	tape_output u_output (
		.clk          (clk),
		.reset        (reset),
		.clk_3mhz_en  (clk_3mhz_en),
		.cs1_cntrl    (cs1_cntrl),
		.sample       (sample),
		.sample_valid (sample_valid),
		.tick         (tick),
		.tape_audio   (tape_audio),
		.ctrl         (ctrl.play)
	);

endmodule

/* sim/tape_checker.sv */
module tape_checker #(
	parameter int memory_size = 8192
) (
	input logic        clk,
	input logic        reset,
	input logic [13:0] adr,
	input logic        cs,
	input logic [3:0]  sel,
	input logic        we,
	input logic [31:0] d,
	input logic [31:0] q,
	input logic [15:0] tape_audio
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int depth = memory_size / 4;
	localparam logic [tape_pkg::ptr_w-1:0] mask = tape_pkg::ptr_w'(depth - 1);

	logic [31:0]                mem [depth]; // mirror of the sample memory
	logic                       m_play;
	logic                       m_one;
	tape_pkg::fmt_t             m_fmt;
	logic [10:0]                m_rate;
	logic [tape_pkg::ptr_w-1:0] m_head;
	logic [tape_pkg::ptr_w-1:0] m_tail;
	int                         errors = 0;
	int                         checks = 0;
	logic                       capturing = 1'b0;
	logic                       mute_watch = 1'b0;
	logic [15:0]                last_obs;
	logic [15:0]                last_exp;
	logic [15:0]                obs[$];
	logic [15:0]                exp_q[$];

	always @(posedge clk) begin
		logic [31:0] want;
		if (reset) begin
			m_play = 1'b0;
			m_one  = 1'b0;
			m_fmt  = tape_pkg::mono8;
			m_rate = '1;
			m_head = '0;
			m_tail = '0;
		end else if (cs && we && !adr[0]) begin
			for (int i = 0; i < 4; i++)
				if (sel[i])
					mem[adr[13:1] & mask][31 - 8*i -: 8] = d[31 - 8*i -: 8];
		end else if (cs && we && adr[3:1] == 3'd0) begin
			if (sel[1]) begin
				m_one  = d[19];
				m_fmt  = tape_pkg::fmt_t'(d[18:17]);
				m_play = d[16];
			end
			if (sel[2])
				m_rate[10:8] = d[10:8];
			if (sel[3])
				m_rate[7:0] = d[7:0];
		end else if (cs && we && adr[3:1] == 3'd1) begin
			if (sel[0])
				m_head[13:8] = d[29:24];
			if (sel[1])
				m_head[7:0] = d[23:16];
			m_head = m_head & mask; // head wraps to memory depth
			if (sel[2])
				m_tail[13:8] = d[13:8];
			if (sel[3])
				m_tail[7:0] = d[7:0];
		end
		if (!reset && cs && !we && adr[0]) begin
			case (adr[3:1])
			3'd0: want = {12'h000, m_one, m_fmt, m_play, 5'h00, m_rate};
			3'd1: want = {2'b00, m_head, 2'b00, m_tail};
			3'd2: want = {16'(memory_size), 16'h0000};
			default: want = '0;
			endcase
			checks++;
			if (q !== want) begin
				errors++;
				$display("ERROR t=%0t q expected %h got %h", $time, want, q);
			end
		end
		if (capturing && tape_audio !== last_obs) begin
			obs.push_back(tape_audio);
			last_obs = tape_audio;
		end
		if (mute_watch) begin
			checks++;
			if (tape_audio !== 16'h0000) begin
				errors++;
				$display("ERROR t=%0t tape_audio expected %h got %h", $time, 16'h0000,
				         tape_audio);
			end
		end
	end

	task automatic push_sample(input logic [15:0] v);
		if (v != last_exp)
			exp_q.push_back(v);
		last_exp = v;
	endtask

	// expected change sequence from the mirrored memory and registers
	task automatic begin_capture();
		logic [31:0] w;
		logic [8:0]  s8;
		logic [16:0] s16;
		logic        pulse;
		pulse = 1'b0;
		obs.delete();
		exp_q.delete();
		last_obs = tape_audio;
		last_exp = tape_audio;
		for (logic [tape_pkg::ptr_w-1:0] p = m_head; p != m_tail; p = (p + 1) & mask) begin
			w = mem[p];
			if (m_one) begin
				for (int b = 31; b >= 0; b--) begin
					pulse = ~pulse;
					push_sample({pulse, 1'b1, 14'h0});
					pulse = pulse ^ w[b];
					push_sample({pulse, 1'b1, 14'h0});
				end
			end else begin
				case (m_fmt)
				tape_pkg::mono8: for (int k = 0; k < 4; k++)
					push_sample({~w[31 - 8*k], w[30 - 8*k -: 7], w[31 - 8*k -: 8]});
				tape_pkg::mono16: begin
					push_sample({w[23:16], w[31:24]});
					push_sample({w[7:0], w[15:8]});
				end
				tape_pkg::stereo8: for (int k = 0; k < 2; k++) begin
					s8 = w[31 - 16*k -: 8] + w[23 - 16*k -: 8];
					push_sample({~s8[8], s8[7:1], s8[8:1]});
				end
				default: begin
					s16 = $signed({w[23:16], w[31:24]}) + $signed({w[7:0], w[15:8]});
					push_sample(s16[16:1]);
				end
				endcase
			end
		end
		capturing = 1'b1;
	endtask

	task automatic finish_capture(input int max_cycles);
		int n;
		n = 0;
		while (obs.size() < exp_q.size() && n < max_cycles) begin
			@(posedge clk);
			n++;
		end
		capturing = 1'b0;
		checks++;
		if (obs.size() != exp_q.size()) begin
			errors++;
			$display("playback gave %0d sample changes where %0d were expected",
			         obs.size(), exp_q.size());
		end
		for (int i = 0; i < obs.size() && i < exp_q.size(); i++) begin
			checks++;
			if (obs[i] !== exp_q[i]) begin
				errors++;
				$display("ERROR t=%0t tape_audio[%0d] expected %h got %h", $time, i,
				         exp_q[i], obs[i]);
			end
		end
		m_head = m_tail; // all words consumed
	endtask

	task automatic note_fetches(input int n);
		m_head = (m_head + tape_pkg::ptr_w'(n)) & mask;
	endtask

	// waits on falling edges for the first sample to reach the output
	task automatic expect_sound(input int max_cycles);
		int n;
		n = 0;
		while (tape_audio === 16'h0000 && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (tape_audio === 16'h0000) begin
			errors++;
			$display("no sample reached tape_audio within %0d cycles", max_cycles);
		end
	endtask

	task automatic expect_silent();
		@(posedge clk);
		@(negedge clk);
		checks++;
		if (tape_audio !== 16'h0000) begin
			errors++;
			$display("ERROR t=%0t tape_audio expected %h got %h", $time, 16'h0000, tape_audio);
		end
	endtask

endmodule

/* sim/tape_tb.sv */
module tape_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int memory_size = 8192;
	localparam int depth       = memory_size / 4;
	// words x samples per word x slowest rate (3+1) x 4 cycles, plus margin
	localparam int budget = (8*4 + 6*2 + 6*2 + 6*1 + 3*64 + 6*4) * 4 * 4 + 40000;

	logic        clk;
	logic        reset;
	logic        clk_3mhz_en;
	logic [13:0] adr;
	logic        cs;
	logic [3:0]  sel;
	logic        we;
	logic [31:0] d;
	logic        cs1_cntrl;
	logic [31:0] q;
	logic [15:0] tape_audio;
	int          tests = 0;

	tape_top #(.memory_size(memory_size)) uut (.*);

	tape_checker #(.memory_size(memory_size)) chk (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		clk_3mhz_en = 1'b0;
		forever begin
			repeat (3) @(negedge clk) clk_3mhz_en = 1'b0;
			@(negedge clk) clk_3mhz_en = 1'b1;
		end
	end

	initial begin
		#(longint'(budget) * 40);
		$display("watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	task automatic bus_write(input logic [13:0] a, input logic [3:0] s, input logic [31:0] v);
		@(negedge clk);
		{cs, we, adr, sel, d} = {2'b11, a, s, v};
		@(negedge clk);
		{cs, we} = 2'b00;
	endtask

	task automatic reg_read(input logic [2:0] idx);
		@(negedge clk);
		{cs, we, adr} = {2'b10, 10'h000, idx, 1'b1};
		@(negedge clk);
		cs = 1'b0;
	endtask

	task automatic set_ctrl(input logic [3:0] f, input logic [10:0] rate);
		bus_write({10'h000, tape_pkg::reg_ctrl, 1'b1}, 4'hf, {12'h000, f, 5'h00, rate});
	endtask

	task automatic load_words(input int start, input int n);
		for (int k = 0; k < n; k++) begin
			bus_write(14'((start + k) % depth) << 1, 4'hf, $urandom);
			bus_write(14'((start + k) % depth) << 1, 4'($urandom), $urandom); // partial lanes
		end
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		$display("%s: %s", name, (chk.errors == err_before) ? "ok" : "FAILED");
	endtask

	// f is {one_bit, stereo, wide}, spw samples per word
	task automatic play(input string name, input logic [2:0] f, input int start,
	                    input int n, input int spw);
		int          e;
		logic [10:0] rate;
		e    = chk.errors;
		rate = 11'($urandom_range(3));
		set_ctrl(4'h0, rate);
		load_words(start, n);
		bus_write({10'h000, tape_pkg::reg_ptr, 1'b1}, 4'hf,
		          {2'b00, 14'(start), 2'b00, 14'((start + n) % depth)});
		set_ctrl({f, 1'b1}, rate);
		chk.begin_capture();
		chk.finish_capture(n * spw * (rate + 1) * 4 + 200);
		reg_read(tape_pkg::reg_ptr);
		set_ctrl(4'h0, rate);
		chk.expect_silent();
		report(name, e);
	endtask

	initial begin
		int e;
		void'($urandom(32'h2ea1_ce42));
		{cs, we, adr, sel, d} = '0;
		cs1_cntrl = 1'b1;
		reset     = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		e = chk.errors;
		for (int i = 0; i < 40; i++) begin
			if (i % 2 == 0)
				bus_write({10'h000, tape_pkg::reg_ctrl, 1'b1}, 4'($urandom),
				          $urandom & 32'hfffe_ffff); // stay stopped
			else
				bus_write({10'h000, tape_pkg::reg_ptr, 1'b1}, 4'($urandom), $urandom);
			reg_read(tape_pkg::reg_ctrl);
			reg_read(tape_pkg::reg_ptr);
		end
		reg_read(tape_pkg::reg_size);
		report("register readback", e);

		play("mono8", 3'b000, 100, 8, 4);
		play("mono16", 3'b001, 300, 6, 2);
		play("stereo8", 3'b010, 500, 6, 2);
		play("stereo16", 3'b011, 700, 6, 1);
		play("one bit pulse", 3'b100, 900, 3, 64);
		play("pointer wrap and stop", 3'b000, depth - 3, 6, 4);

		e = chk.errors;
		load_words(40, 4);
		bus_write({10'h000, tape_pkg::reg_ptr, 1'b1}, 4'hf, {2'b00, 14'd40, 2'b00, 14'd44});
		set_ctrl(4'h1, 11'd0);
		chk.expect_sound(100);
		cs1_cntrl = 1'b0;
		repeat (4) @(negedge clk); // next enable clears the output
		chk.mute_watch = 1'b1;
		chk.note_fetches(1); // first word is held, no tick consumes it
		reg_read(tape_pkg::reg_ptr);
		repeat (100) @(negedge clk);
		reg_read(tape_pkg::reg_ptr);
		chk.mute_watch = 1'b0;
		set_ctrl(4'h0, 11'd0);
		cs1_cntrl = 1'b1;
		report("mute", e);

		$display("tests %0d, checks %0d, errors %0d", tests, chk.checks, chk.errors);
		if (chk.errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sim.f */
logic/tape_pkg.sv
logic/tape_ctrl_if.sv
logic/tape_regs.sv
logic/tape_buffer.sv
logic/tape_unpack.sv
logic/tape_output.sv
logic/tape_top.sv
sim/tape_checker.sv
sim/tape_tb.sv
